// ==== design/sd_pkg.sv ====
package sd_pkg;

    localparam int NUM_SLOTS  = 2;
    localparam int SLOT_W     = 1;   // Address bit 3 picks the slot

    localparam int FRAME_BITS = 48;
    localparam int LAST_BIT   = FRAME_BITS - 1;
    localparam int HEAD_BITS  = FRAME_BITS - 8;   // Start, direction, index and argument
    localparam int RESP_LSB   = 8;                // Response word sits above CRC7 and stop bit

    localparam int REG_STATUS = 4;

    typedef logic [SLOT_W-1:0]     slot_idx_t;
    typedef logic [2:0]            reg_idx_t;
    typedef logic [7:0]            byte_t;
    typedef logic [31:0]           sd_arg_t;
    typedef logic [5:0]            sd_cmd_idx_t;
    typedef logic [FRAME_BITS-1:0] sd_frame_t;
    typedef logic [HEAD_BITS-1:0]  sd_head_t;
    typedef logic [6:0]            sd_crc_t;
    typedef logic [5:0]            bit_cnt_t;
    typedef logic [NUM_SLOTS-1:0]  slot_mask_t;

    typedef enum logic [2:0] {
        IDLE,
        LOAD,
        CRC,
        TXCMD,
        RXCMD
    } sd_chan_state_t;

    // Channel sequencer register holding the state and the position inside the frame
    typedef struct packed {
        sd_chan_state_t state;
        bit_cnt_t       count;
    } sd_chan_reg_t;

    // CPU side request towards one slot
    typedef struct packed {
        logic [3:0] arg_we;      // One enable per argument byte
        logic       cmd_we;
        logic       status_rd;
        byte_t      wdata;
    } sd_slot_req_t;

    // What a slot offers for readback
    typedef struct packed {
        sd_arg_t resp;
        logic    resp_ready;
        logic    busy;
    } sd_slot_view_t;

endpackage

// ==== design/sd_crc7.sv ====
module sd_crc7 (
    input  logic             clk,
    input  logic             rst,
    input  logic             i_load,
    input  sd_pkg::sd_head_t i_head,
    output sd_pkg::sd_crc_t  o_crc,
    output logic             o_valid
);

    logic valid_q;

    // Serial CRC7 with x^7 + x^3 + 1 unrolled over the whole head MSB first
    function automatic sd_pkg::sd_crc_t crc7_of(input sd_pkg::sd_head_t head);
        sd_pkg::sd_crc_t crc;
        logic            fb;
        crc = '0;
        for (int i = sd_pkg::HEAD_BITS - 1; i >= 0; i--) begin
            fb  = crc[6] ^ head[i];
            crc = {crc[5:0], 1'b0};
            if (fb) begin
                crc = crc ^ 7'h09;   // Feedback into x^3 and x^0
            end
        end
        return crc;
    endfunction

    always_ff @(posedge clk) begin
        if (i_load) begin
            o_crc <= crc7_of(i_head);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (i_load) begin
            valid_q <= 1'b1;
        end
    end

    // The old result is about to be replaced while a load is pending
    assign o_valid = valid_q & ~i_load;

endmodule

// ==== design/sd_reg_decode.sv ====
module sd_reg_decode (
    input  logic                 [3:0] i_addr,
    input  sd_pkg::byte_t              i_data,
    input  logic                       i_cs,
    input  logic                       i_rw,
    output sd_pkg::sd_slot_req_t       o_req [sd_pkg::NUM_SLOTS]
);

    sd_pkg::slot_idx_t slot;
    sd_pkg::reg_idx_t  reg_idx;
    logic              wr;
    logic              rd;
    logic [3:0]        arg_en;
    logic              cmd_wr;
    logic              stat_rd;

    assign slot    = i_addr[3];
    assign reg_idx = i_addr[2:0];

    assign wr = i_cs & ~i_rw;
    assign rd = i_cs & i_rw;

    // Registers 0 to 3 are the argument bytes with the least significant first
    always_comb begin
        arg_en = '0;
        if (wr && reg_idx < sd_pkg::REG_STATUS) begin
            arg_en = 4'b0001 << reg_idx[1:0];
        end
    end

    assign cmd_wr  = wr && reg_idx == sd_pkg::REG_STATUS;
    assign stat_rd = rd && reg_idx == sd_pkg::REG_STATUS;

    // Write data goes to every slot but only the addressed one gets strobes
    always_comb begin
        for (int s = 0; s < sd_pkg::NUM_SLOTS; s++) begin
            o_req[s].arg_we    = '0;
            o_req[s].cmd_we    = 1'b0;
            o_req[s].status_rd = 1'b0;
            o_req[s].wdata     = i_data;
            if (slot == sd_pkg::slot_idx_t'(s)) begin
                o_req[s].arg_we    = arg_en;
                o_req[s].cmd_we    = cmd_wr;
                o_req[s].status_rd = stat_rd;
            end
        end
    end

endmodule

// ==== design/sd_cmd_channel.sv ====
module sd_cmd_channel (
    input  logic                  clk,
    input  logic                  rst,
    input  sd_pkg::sd_slot_req_t  i_req,
    input  logic                  i_sd_clk,
    input  logic                  i_sd_cmd,
    output logic                  o_sd_cmd,
    output sd_pkg::sd_slot_view_t o_view
);

    sd_pkg::sd_arg_t      arg;
    sd_pkg::sd_cmd_idx_t  cmd_idx;
    sd_pkg::sd_chan_reg_t cur;
    sd_pkg::sd_chan_reg_t nxt;

    sd_pkg::sd_head_t     tx_head;
    sd_pkg::sd_frame_t    tx_frame;
    sd_pkg::sd_crc_t      crc;
    logic                 crc_load;
    logic                 crc_valid;

    sd_pkg::sd_frame_t    rx_buf;
    sd_pkg::sd_arg_t      resp;
    logic                 resp_ready;

    logic                 start_tx;
    logic                 start_rx;
    logic                 rx_done;

    assign start_tx = i_req.cmd_we && cur.state == sd_pkg::IDLE;

    // Card start bit is sampled like every other bit, while the SD clock is low
    assign start_rx = cur.state == sd_pkg::IDLE && !i_req.cmd_we && !i_sd_clk && !i_sd_cmd;

    // Argument bytes can be written at any time
    always_ff @(posedge clk) begin
        for (int b = 0; b < 4; b++) begin
            if (i_req.arg_we[b]) begin
                arg[8*b +: 8] <= i_req.wdata;
            end
        end
        if (start_tx) begin
            cmd_idx <= i_req.wdata[5:0];
        end
    end

    // The head is taken in LOAD so later argument writes only reach the next command
    always_ff @(posedge clk) begin
        if (cur.state == sd_pkg::LOAD) begin
            tx_head <= {1'b0, 1'b1, cmd_idx, arg};
        end
    end

    assign crc_load = cur.state == sd_pkg::CRC;

    sd_crc7 sd_crc7_i (
        .clk     (clk),
        .rst     (rst),
        .i_load  (crc_load),
        .i_head  (tx_head),
        .o_crc   (crc),
        .o_valid (crc_valid)
    );

    assign tx_frame = {tx_head, crc, 1'b1};

    always_comb begin
        nxt     = cur;
        rx_done = 1'b0;
        case (cur.state)
            sd_pkg::IDLE: begin
                if (start_tx) begin
                    nxt.state = sd_pkg::LOAD;
                end else if (start_rx) begin
                    nxt.state = sd_pkg::RXCMD;
                end
            end
            sd_pkg::LOAD: nxt.state = sd_pkg::CRC;
            sd_pkg::CRC:  nxt.state = sd_pkg::TXCMD;
            sd_pkg::TXCMD: begin
                // Bit boundaries follow edges with the SD clock high
                if (i_sd_clk && crc_valid) begin
                    if (cur.count == sd_pkg::bit_cnt_t'(sd_pkg::LAST_BIT)) begin
                        nxt.state = sd_pkg::IDLE;
                        nxt.count = '0;
                    end else begin
                        nxt.count = cur.count + 1'b1;
                    end
                end
            end
            sd_pkg::RXCMD: begin
                if (!i_sd_clk) begin
                    if (cur.count == sd_pkg::bit_cnt_t'(sd_pkg::LAST_BIT - 1)) begin
                        rx_done   = 1'b1;
                        nxt.state = sd_pkg::IDLE;
                        nxt.count = '0;
                    end else begin
                        nxt.count = cur.count + 1'b1;
                    end
                end
            end
            default: begin
                nxt.state = sd_pkg::IDLE;
                nxt.count = '0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cur.state <= sd_pkg::IDLE;
            cur.count <= '0;
        end else begin
            cur <= nxt;
        end
    end

    // Start bit lands in bit 47, then bits 46 down to 0 follow the count
    always_ff @(posedge clk) begin
        if (start_rx) begin
            rx_buf[sd_pkg::LAST_BIT] <= i_sd_cmd;
        end
        if (cur.state == sd_pkg::RXCMD && !i_sd_clk) begin
            rx_buf[sd_pkg::LAST_BIT - 1 - int'(cur.count)] <= i_sd_cmd;
        end
        if (rx_done) begin
            resp <= rx_buf[sd_pkg::RESP_LSB +: $bits(sd_pkg::sd_arg_t)];   // Complete before bit 0
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            resp_ready <= 1'b0;
        end else if (rx_done) begin
            resp_ready <= 1'b1;   // A new response beats a status read in the same cycle
        end else if (i_req.status_rd) begin
            resp_ready <= 1'b0;
        end
    end

    always_comb begin
        o_sd_cmd = 1'b1;   // Line idles high
        if (cur.state == sd_pkg::TXCMD) begin
            o_sd_cmd = tx_frame[sd_pkg::LAST_BIT - int'(cur.count)];
        end
    end

    assign o_view.resp       = resp;
    assign o_view.resp_ready = resp_ready;
    assign o_view.busy       = cur.state != sd_pkg::IDLE;

endmodule

// ==== design/sd_readback_mux.sv ====
module sd_readback_mux (
    input  logic                  [3:0] i_addr,
    input  sd_pkg::sd_slot_view_t       i_view [sd_pkg::NUM_SLOTS],
    output sd_pkg::byte_t               o_data
);

    sd_pkg::slot_idx_t     slot;
    sd_pkg::reg_idx_t      reg_idx;
    sd_pkg::sd_slot_view_t view;

    assign slot    = i_addr[3];
    assign reg_idx = i_addr[2:0];

    assign view = i_view[slot];

    always_comb begin
        o_data = '0;   // Registers 5 to 7 read as zero
        if (reg_idx < sd_pkg::REG_STATUS) begin
            o_data = view.resp[8*reg_idx[1:0] +: 8];
        end else if (reg_idx == sd_pkg::REG_STATUS) begin
            o_data = {6'b0, view.busy, view.resp_ready};
        end
    end

endmodule

// ==== design/sd_host_top.sv ====
module sd_host_top (
    input  logic               clk,
    input  logic               rst,

    input  logic         [3:0] i_addr,
    input  sd_pkg::byte_t      i_data,
    input  logic               i_cs,
    input  logic               i_rw,
    output sd_pkg::byte_t      o_data,

    input  logic               i_sd_clk,
    input  sd_pkg::slot_mask_t i_sd_cmd,
    output sd_pkg::slot_mask_t o_sd_cmd
);

    sd_pkg::sd_slot_req_t  req  [sd_pkg::NUM_SLOTS];
    sd_pkg::sd_slot_view_t view [sd_pkg::NUM_SLOTS];

    sd_reg_decode sd_reg_decode_i (
        .i_addr (i_addr),
        .i_data (i_data),
        .i_cs   (i_cs),
        .i_rw   (i_rw),
        .o_req  (req)
    );

    for (genvar s = 0; s < sd_pkg::NUM_SLOTS; s++) begin : g_slot
        sd_cmd_channel sd_cmd_channel_i (
            .clk      (clk),
            .rst      (rst),
            .i_req    (req[s]),
            .i_sd_clk (i_sd_clk),
            .i_sd_cmd (i_sd_cmd[s]),
            .o_sd_cmd (o_sd_cmd[s]),
            .o_view   (view[s])
        );
    end

    sd_readback_mux sd_readback_mux_i (
        .i_addr (i_addr),
        .i_view (view),
        .o_data (o_data)
    );

endmodule

// ==== sim/sd_host_assertions.sv ====
module sd_cmd_channel_assertions (
    input logic                   clk,
    input logic                   rst,
    input sd_pkg::sd_chan_state_t i_state,
    input sd_pkg::bit_cnt_t       i_count,
    input logic                   i_line,
    input logic                   i_cmd_we,
    input logic                   i_busy
);

    timeunit 1ns;
    timeprecision 1ps;

    // Nothing goes out before the frame is complete
    line_high_before_tx: assert property (
        @(posedge clk) disable iff (rst)
        (i_state == sd_pkg::IDLE || i_state == sd_pkg::LOAD || i_state == sd_pkg::CRC)
            |-> i_line
    ) else $error("command line low outside TXCMD");

    count_in_frame: assert property (
        @(posedge clk) disable iff (rst)
        i_count <= sd_pkg::bit_cnt_t'(sd_pkg::LAST_BIT)
    ) else $error("bit count beyond the last frame bit");

    busy_after_start: assert property (
        @(posedge clk) disable iff (rst)
        (i_state == sd_pkg::IDLE && i_cmd_we) |=> i_busy
    ) else $error("channel not busy after a command write in IDLE");

endmodule

bind sd_cmd_channel sd_cmd_channel_assertions sd_cmd_channel_assertions_i (
    .clk      (clk),
    .rst      (rst),
    .i_state  (cur.state),
    .i_count  (cur.count),
    .i_line   (o_sd_cmd),
    .i_cmd_we (i_req.cmd_we),
    .i_busy   (o_view.busy)
);

// ==== sim/sd_host_tb.sv ====
module sd_host_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int HALF_PERIOD    = 10;
    localparam int RESET_CYCLES   = 10;
    localparam int SETTLE         = 2;      // Outputs are read this long after the falling edge
    localparam int TIMEOUT_CYCLES = 4000;   // All tests need roughly 700 cycles
    localparam int RAND_SEED      = 32'h1034962a;

    logic               clk = 1'b0;
    logic               rst;
    logic [3:0]         addr;
    sd_pkg::byte_t      wdata;
    logic               cs;
    logic               rw;
    sd_pkg::byte_t      rdata;
    logic               sd_clk = 1'b0;
    sd_pkg::slot_mask_t sd_cmd_in;
    sd_pkg::slot_mask_t sd_cmd_out;
    int                 cycle_count = 0;

    sd_host_top sd_host_top_i (
        .clk      (clk),
        .rst      (rst),
        .i_addr   (addr),
        .i_data   (wdata),
        .i_cs     (cs),
        .i_rw     (rw),
        .o_data   (rdata),
        .i_sd_clk (sd_clk),
        .i_sd_cmd (sd_cmd_in),
        .o_sd_cmd (sd_cmd_out)
    );

    always #HALF_PERIOD clk = ~clk;

    // SD clock is high in every other system clock cycle
    always @(negedge clk) begin
        sd_clk <= ~sd_clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Test failed");
            $fatal(1);
        end
    end

    task automatic check_value(input logic [47:0] actual, input logic [47:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t ns: %s, got 0x%0h, expected 0x%0h",
                     $time, what, actual, expected);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    // CRC7 as the SD card spec shifts it with x^7 + x^3 + 1 starting from zero
    function automatic sd_pkg::sd_crc_t crc7_ref(input logic [39:0] head);
        sd_pkg::sd_crc_t c;
        logic            inv;
        c = '0;
        for (int i = 39; i >= 0; i--) begin
            inv  = head[i] ^ c[6];
            c[6] = c[5];
            c[5] = c[4];
            c[4] = c[3];
            c[3] = c[2] ^ inv;
            c[2] = c[1];
            c[1] = c[0];
            c[0] = inv;
        end
        return c;
    endfunction

    // Direction bit is 1 for a host command and 0 for a card response
    function automatic sd_pkg::sd_frame_t build_frame(input logic dir,
                                                      input sd_pkg::sd_cmd_idx_t idx,
                                                      input sd_pkg::sd_arg_t arg);
        logic [39:0] head;
        head = {1'b0, dir, idx, arg};
        return {head, crc7_ref(head), 1'b1};
    endfunction

    task automatic write_reg(input sd_pkg::slot_idx_t slot, input sd_pkg::reg_idx_t reg_idx,
                             input sd_pkg::byte_t data);
        @(negedge clk);
        addr  = {slot, reg_idx};
        wdata = data;
        cs    = 1'b1;
        rw    = 1'b0;
        @(negedge clk);
        cs = 1'b0;
    endtask

    task automatic read_reg(input sd_pkg::slot_idx_t slot, input sd_pkg::reg_idx_t reg_idx,
                            output sd_pkg::byte_t data);
        @(negedge clk);
        addr = {slot, reg_idx};
        cs   = 1'b1;
        rw   = 1'b1;
        #SETTLE;
        data = rdata;
        @(negedge clk);   // A status read clears resp_ready at the edge in between
        cs = 1'b0;
        rw = 1'b0;
    endtask

    task automatic write_arg(input sd_pkg::slot_idx_t slot, input sd_pkg::sd_arg_t arg);
        for (int b = 0; b < 4; b++) begin
            write_reg(slot, sd_pkg::reg_idx_t'(b), arg[8*b +: 8]);
        end
    endtask

    task automatic write_cmd(input sd_pkg::slot_idx_t slot, input sd_pkg::sd_cmd_idx_t idx);
        write_reg(slot, sd_pkg::reg_idx_t'(sd_pkg::REG_STATUS), {2'b00, idx});
    endtask

    task automatic expect_status(input sd_pkg::slot_idx_t slot, input sd_pkg::byte_t expected,
                                 input string what);
        sd_pkg::byte_t data;
        read_reg(slot, sd_pkg::reg_idx_t'(sd_pkg::REG_STATUS), data);
        check_value(48'(data), 48'(expected), $sformatf("slot %0d %s", slot, what));
    endtask

    // Samples the command line in the cycles where the SD clock is high
    task automatic collect_frame(input sd_pkg::slot_idx_t slot, output sd_pkg::sd_frame_t frame);
        sd_pkg::sd_frame_t f;
        do begin
            @(negedge clk);
            #SETTLE;
        end while (sd_cmd_out[slot] !== 1'b0);
        for (int i = sd_pkg::LAST_BIT; i >= 0; i--) begin
            while (sd_clk !== 1'b1) begin
                @(negedge clk);
                #SETTLE;
            end
            f[i] = sd_cmd_out[slot];
            check_value(48'(sd_cmd_out[~slot]), 48'(1), "other slot keeps its command line high");
            if (i > 0) begin
                @(negedge clk);
                #SETTLE;
            end
        end
        frame = f;
    endtask

    // Plays a card that changes the line as the SD clock rises
    task automatic play_card(input sd_pkg::slot_idx_t slot, input sd_pkg::sd_frame_t frame);
        for (int i = sd_pkg::LAST_BIT; i >= 0; i--) begin
            @(negedge clk);
            while (sd_clk !== 1'b0) begin   // Still the old value so low means it rises now
                @(negedge clk);
            end
            sd_cmd_in[slot] = frame[i];
        end
        @(negedge clk);
        @(negedge clk);
        sd_cmd_in[slot] = 1'b1;
    endtask

    task automatic check_response(input sd_pkg::slot_idx_t slot, input sd_pkg::sd_arg_t resp);
        sd_pkg::byte_t data;
        expect_status(slot, 8'h01, "response ready after the card frame");
        for (int b = 0; b < 4; b++) begin
            read_reg(slot, sd_pkg::reg_idx_t'(b), data);
            check_value(48'(data), 48'(resp[8*b +: 8]),
                        $sformatf("slot %0d response byte %0d", slot, b));
        end
        expect_status(slot, 8'h00, "second status read after clear");
    endtask

    task automatic after_reset();
        check_value(48'(sd_cmd_out), 48'(2'b11), "command lines idle high after reset");
        expect_status(1'b0, 8'h00, "status after reset");
        expect_status(1'b1, 8'h00, "status after reset");
    endtask

    task automatic transmit_command();
        sd_pkg::sd_arg_t     arg;
        sd_pkg::sd_cmd_idx_t idx;
        sd_pkg::sd_frame_t   got;
        arg = $urandom();
        idx = sd_pkg::sd_cmd_idx_t'($urandom());
        fork
            collect_frame(1'b0, got);
            begin
                write_arg(1'b0, arg);
                write_cmd(1'b0, idx);
            end
        join
        check_value(got, build_frame(1'b1, idx, arg), "slot 0 command frame");
    endtask

    task automatic busy_and_ignored_start();
        sd_pkg::sd_arg_t     arg;
        sd_pkg::sd_cmd_idx_t idx;
        sd_pkg::sd_frame_t   got;
        arg = $urandom();
        idx = sd_pkg::sd_cmd_idx_t'($urandom());
        write_arg(1'b0, arg);
        fork
            collect_frame(1'b0, got);
            begin
                write_cmd(1'b0, idx);
                write_cmd(1'b0, idx ^ 6'h2a);   // Lands while the slot is still busy
                expect_status(1'b0, 8'h02, "busy during transmission");
            end
        join
        check_value(got, build_frame(1'b1, idx, arg), "frame with a start written while busy");
        expect_status(1'b0, 8'h00, "busy after the stop bit");
        // A second frame would have started long before this window ends
        repeat (2 * sd_pkg::FRAME_BITS) begin
            @(negedge clk);
            #SETTLE;
            check_value(48'(sd_cmd_out[0]), 48'(1), "slot 0 line after a single frame");
        end
    endtask

    task automatic capture_response();
        sd_pkg::sd_arg_t resp;
        resp = $urandom();
        play_card(1'b1, build_frame(1'b0, sd_pkg::sd_cmd_idx_t'($urandom()), resp));
        check_response(1'b1, resp);
    endtask

    task automatic slots_in_parallel();
        sd_pkg::sd_arg_t     arg;
        sd_pkg::sd_arg_t     resp;
        sd_pkg::sd_cmd_idx_t idx;
        sd_pkg::sd_frame_t   got;
        arg  = $urandom();
        resp = $urandom();
        idx  = sd_pkg::sd_cmd_idx_t'($urandom());
        fork
            collect_frame(1'b0, got);
            begin
                write_arg(1'b0, arg);
                write_cmd(1'b0, idx);
            end
            play_card(1'b1, build_frame(1'b0, sd_pkg::sd_cmd_idx_t'($urandom()), resp));
        join
        check_value(got, build_frame(1'b1, idx, arg), "slot 0 frame next to a receiving slot");
        expect_status(1'b0, 8'h00, "status of the sending slot");
        check_response(1'b1, resp);
    endtask

    task automatic unmapped_registers();
        sd_pkg::byte_t data;
        for (int s = 0; s < sd_pkg::NUM_SLOTS; s++) begin
            for (int r = 5; r < 8; r++) begin
                write_reg(sd_pkg::slot_idx_t'(s), sd_pkg::reg_idx_t'(r), 8'hff);
                read_reg(sd_pkg::slot_idx_t'(s), sd_pkg::reg_idx_t'(r), data);
                check_value(48'(data), 48'(0), $sformatf("slot %0d register %0d", s, r));
            end
            expect_status(sd_pkg::slot_idx_t'(s), 8'h00, "status after unmapped writes");
        end
    endtask

    initial begin
        void'($urandom(RAND_SEED));
        rst       = 1'b1;
        addr      = '0;
        wdata     = '0;
        cs        = 1'b0;
        rw        = 1'b0;
        sd_cmd_in = '1;
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
        // Known CMD0 frame ends in 0x95
        check_value(48'(crc7_ref(40'h40_0000_0000)), 48'(7'h4a), "reference CRC7 of CMD0");
        after_reset();
        transmit_command();
        busy_and_ignored_start();
        capture_response();
        slots_in_parallel();
        unmapped_registers();
        $display("Test completed successfully");
        $finish;
    end

endmodule

// ==== files.f ====
design/sd_pkg.sv
design/sd_crc7.sv
design/sd_reg_decode.sv
design/sd_cmd_channel.sv
design/sd_readback_mux.sv
design/sd_host_top.sv
sim/sd_host_assertions.sv
sim/sd_host_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps --top-module sd_host_tb \
    -f files.f -o sd_host_sim \
    && ./obj_dir/sd_host_sim \
    || { echo "simulation run did not pass"; exit 1; }
